//--- flist.f
src/dcache_geom_pkg.sv
src/dcache_bus_pkg.sv
src/dcache_way.sv
src/dcache_victim_sel.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module dcache_tb -f flist.f -o dcache_sim
	./obj_dir/dcache_sim | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then \
		echo "simulation reported errors"; \
		exit 1; \
	fi
	@if ! grep -q "PASS: all tests" sim.log; then \
		echo "simulation ended without a result line"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- tb/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
        import dcache_geom_pkg::*;
        import dcache_bus_pkg::*;

        localparam int TIMEOUT = 200;
        localparam int MEM_WORDS = 256;

        logic CLK;
        logic nRST;
        dcache_cpu_req_t cpu_req;
        logic halt;
        logic dhit;
        logic flushed;
        logic [WORD_W-1:0] dmemload;
        dcache_mem_req_t mem_req;
        logic dwait;
        logic [WORD_W-1:0] dload;

        // last stored value per word, starts as the memory pattern
        logic [WORD_W-1:0] shadow [MEM_WORDS];
        logic [7:0] rng;

        dcache_top UUT (
                .CLK(CLK),
                .nRST(nRST),
                .cpu_req(cpu_req),
                .halt(halt),
                .dhit(dhit),
                .flushed(flushed),
                .dmemload(dmemload),
                .mem_req(mem_req),
                .dwait(dwait),
                .dload(dload)
        );

        mem_model u_mem (
                .CLK(CLK),
                .nRST(nRST),
                .mem_req(mem_req),
                .dwait(dwait),
                .dload(dload)
        );

        function automatic logic [WORD_W-1:0] init_word(input int w);
                return ~(WORD_W'(w) << 2);
        endfunction

        // stores update the shadow, loads read it back
        function automatic logic [WORD_W-1:0] reference(input logic wr,
                                                        input logic [WORD_W-1:0] addr,
                                                        input logic [WORD_W-1:0] data);
                if (wr) begin
                        shadow[addr[9:2]] = data;
                end
                return shadow[addr[9:2]];
        endfunction

        function automatic logic [7:0] lfsr_next(input logic [7:0] s);
                return {s[0] ^ s[2] ^ s[3] ^ s[4], s[7:1]};
        endfunction

        task automatic stop_run();
                $display("FAIL: see errors above");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic draw_bits(input int n, output logic [31:0] v);
                v = '0;
                for (int k = 0; k < n; k++) begin
                        v = {v[30:0], rng[0]};
                        rng = lfsr_next(rng);
                end
        endtask

        task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                                   input logic [WORD_W-1:0] want);
                assert (got === want) else begin
                        $display("CHECK FAILED at %0t: %s = %h, expected %h",
                                 $time, name, got, want);
                        stop_run();
                end
        endtask

        // holds the request until dhit, returns cycles spent waiting
        task automatic cpu_access(input logic wr, input logic [WORD_W-1:0] addr,
                                  input logic [WORD_W-1:0] data, output int waited);
                waited = 0;
                cpu_req.read = ~wr;
                cpu_req.write = wr;
                cpu_req.addr = addr;
                cpu_req.wdata = data;
                @(negedge CLK);
                while (!dhit) begin
                        waited++;
                        if (waited >= TIMEOUT) begin
                                $display("timeout: no dhit within %0d cycles for address %h",
                                         TIMEOUT, addr);
                                stop_run();
                        end
                        @(negedge CLK);
                end
                @(posedge CLK);
                #1;
                cpu_req = '0;
        endtask

        initial begin
                CLK = 1'b0;
                forever #5 CLK = ~CLK;
        end

        always @(negedge CLK) begin : compare
                logic [WORD_W-1:0] want;
                if (nRST && dhit) begin
                        want = reference(cpu_req.write, cpu_req.addr, cpu_req.wdata);
                        assert (!mem_req.read && !mem_req.write) else begin
                                $display("memory request was active during a hit at %0t",
                                         $time);
                                stop_run();
                        end
                        if (cpu_req.read) begin
                                assert (dmemload === want) else begin
                                        $display("CHECK FAILED at %0t: dmemload = %h, expected %h",
                                                 $time, dmemload, want);
                                        stop_run();
                                end
                        end
                end
        end

        initial begin
                int waited;
                int order [7];
                logic wr;
                logic [31:0] r;
                logic [WORD_W-1:0] addr;
                logic [WORD_W-1:0] blk [3];
                nRST = 1'b0;
                halt = 1'b0;
                cpu_req = '0;
                rng = 8'd39;
                for (int i = 0; i < MEM_WORDS; i++) begin
                        shadow[i] = init_word(i);
                end
                repeat (3) @(posedge CLK);
                #1;
                nRST = 1'b1;

                @(negedge CLK);
                check_value("dhit", 32'(dhit), 32'd0);
                check_value("flushed", 32'(flushed), 32'd0);
                check_value("mem_req.read", 32'(mem_req.read), 32'd0);
                check_value("mem_req.write", 32'(mem_req.write), 32'd0);
                @(posedge CLK);
                #1;

                // miss, then the other word of the block hits at once
                cpu_access(1'b0, 32'h100, '0, waited);
                cpu_access(1'b0, 32'h104, '0, waited);
                check_value("hit wait cycles", 32'(waited), 32'd0);
                cpu_access(1'b0, 32'h20c, '0, waited);
                cpu_access(1'b0, 32'h208, '0, waited);
                check_value("hit wait cycles", 32'(waited), 32'd0);

                cpu_access(1'b1, 32'h030, 32'h1234_5678, waited);
                cpu_access(1'b0, 32'h030, '0, waited);

                // three blocks of set 2 fight over two ways
                blk[0] = 32'h010;
                blk[1] = 32'h050;
                blk[2] = 32'h090;
                for (int b = 0; b < 3; b++) begin
                        cpu_access(1'b1, blk[b], 32'ha500_0000 | blk[b], waited);
                        cpu_access(1'b1, blk[b] + 32'd4, 32'h5a00_0000 | blk[b], waited);
                end
                order = '{0, 2, 0, 1, 2, 1, 0};
                for (int k = 0; k < 7; k++) begin
                        cpu_access(1'b0, blk[order[k]], '0, waited);
                        cpu_access(1'b0, blk[order[k]] + 32'd4, '0, waited);
                end

                // four tags over sets 0 to 3
                for (int n = 0; n < 40; n++) begin
                        draw_bits(5, r);
                        addr = {24'd0, r[4:3], 1'b0, r[1:0], r[2], 2'b00};
                        draw_bits(1, r);
                        wr = r[0];
                        draw_bits(8, r);
                        cpu_access(wr, addr, {8'(n), r[7:0], addr[15:0]}, waited);
                end

                halt = 1'b1;
                waited = 0;
                @(negedge CLK);
                while (!flushed) begin
                        waited++;
                        if (waited >= TIMEOUT) begin
                                $display("timeout: flushed not raised within %0d cycles", TIMEOUT);
                                stop_run();
                        end
                        @(negedge CLK);
                end
                for (int i = 0; i < MEM_WORDS; i++) begin
                        check_value($sformatf("mem[%0d]", i), u_mem.mem[i], shadow[i]);
                end

                $display("PASS: all tests");
                $finish;
        end

endmodule

//--- tb/mem_model.sv
`timescale 1ns/1ps

module mem_model (
        input logic CLK,
        input logic nRST,
        input dcache_bus_pkg::dcache_mem_req_t mem_req,
        output logic dwait,
        output logic [dcache_geom_pkg::WORD_W-1:0] dload
);
        import dcache_geom_pkg::*;

        localparam int DEPTH = 256;

        logic [WORD_W-1:0] mem [DEPTH];
        logic [WORD_W-1:0] addr;
        logic [7:0] word_idx;
        logic active;
        logic [1:0] wait_cnt;
        logic [7:0] lfsr;
        logic [7:0] lfsr_a;
        logic [7:0] lfsr_b;

        // taps 8 6 5 4, shifting right
        function automatic logic [7:0] lfsr_next(input logic [7:0] s);
                return {s[0] ^ s[2] ^ s[3] ^ s[4], s[7:1]};
        endfunction

        // inverted byte address as the power-up pattern
        initial begin
                for (int i = 0; i < DEPTH; i++) begin
                        mem[i] = ~(WORD_W'(i) << 2);
                end
        end

        assign addr = mem_req.addr;
        assign word_idx = addr[9:2];
        assign active = mem_req.read || mem_req.write;
        assign dwait = active && (wait_cnt != 2'd0);
        assign dload = mem[word_idx];
        assign lfsr_a = lfsr_next(lfsr);
        assign lfsr_b = lfsr_next(lfsr_a);

        // wait count of the next transfer, two lfsr bits per draw
        always @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        wait_cnt <= 2'd1;
                        lfsr <= 8'd39;
                end else if (active) begin
                        if (wait_cnt != 2'd0) begin
                                wait_cnt <= wait_cnt - 2'd1;
                        end else begin
                                wait_cnt <= {lfsr[0], lfsr_a[0]};
                                lfsr <= lfsr_b;
                        end
                end
        end

        always @(posedge CLK) begin
                if (active && !dwait && mem_req.write) begin
                        mem[word_idx] <= mem_req.wdata;
                end
        end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
        input logic CLK,
        input logic nRST,
        input dcache_bus_pkg::dcache_cpu_req_t cpu_req,
        input logic halt,
        output logic dhit,
        output logic flushed,
        output logic [dcache_geom_pkg::WORD_W-1:0] dmemload,
        output dcache_bus_pkg::dcache_mem_req_t mem_req,
        input logic dwait,
        input logic [dcache_geom_pkg::WORD_W-1:0] dload
);
        import dcache_geom_pkg::*;
        import dcache_bus_pkg::*;

        logic [IDX_W-1:0] idx;
        logic touch;
        way_cmd_t [NUM_WAYS-1:0] way_cmd;
        way_status_t [NUM_WAYS-1:0] way_status;
        sel_result_t result;

        dcache_ctrl u_ctrl (
                .CLK(CLK),
                .nRST(nRST),
                .cpu_req(cpu_req),
                .halt(halt),
                .dhit(dhit),
                .dmemload(dmemload),
                .flushed(flushed),
                .mem_req(mem_req),
                .dwait(dwait),
                .dload(dload),
                .idx(idx),
                .way_cmd(way_cmd),
                .touch(touch),
                .result(result),
                .way_status(way_status)
        );

        for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
                dcache_way u_way (
                        .CLK(CLK),
                        .nRST(nRST),
                        .idx(idx),
                        .cmp_tag(cpu_req.addr.tag),
                        .cmd(way_cmd[w]),
                        .status(way_status[w])
                );
        end

        dcache_victim_sel u_sel (
                .CLK(CLK),
                .nRST(nRST),
                .way_status(way_status),
                .idx(idx),
                .blk_off(cpu_req.addr.blk_off),
                .touch(touch),
                .result(result)
        );

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
        input logic CLK,
        input logic nRST,
        input dcache_bus_pkg::dcache_cpu_req_t cpu_req,
        input logic halt,
        output logic dhit,
        output logic [dcache_geom_pkg::WORD_W-1:0] dmemload,
        output logic flushed,
        output dcache_bus_pkg::dcache_mem_req_t mem_req,
        input logic dwait,
        input logic [dcache_geom_pkg::WORD_W-1:0] dload,
        output logic [dcache_geom_pkg::IDX_W-1:0] idx,
        output dcache_bus_pkg::way_cmd_t [dcache_geom_pkg::NUM_WAYS-1:0] way_cmd,
        output logic touch,
        input dcache_bus_pkg::sel_result_t result,
        input dcache_bus_pkg::way_status_t [dcache_geom_pkg::NUM_WAYS-1:0] way_status
);
        import dcache_geom_pkg::*;
        import dcache_bus_pkg::*;

        dcache_state_e state, next_state;
        logic [IDX_W-1:0] flush_set, next_flush_set;
        logic flush_way, next_flush_way;
        logic dirty_any;
        logic dirty_way;
        way_status_t vic;
        way_status_t fl;

        function automatic dcache_addr_t blk_addr(input logic [TAG_W-1:0] tag,
                                                  input logic [IDX_W-1:0] set,
                                                  input logic word);
                dcache_addr_t a;
                a.tag = tag;
                a.idx = set;
                a.blk_off = word;
                a.byte_off = 2'b00;
                return a;
        endfunction

        assign idx = (state inside {FLUSH_SCAN, FLUSH_WB0, FLUSH_WB1, FLUSH_DONE}) ?
                     flush_set : cpu_req.addr.idx;
        assign dmemload = result.hit_word;
        assign flushed = (state == FLUSH_DONE);
        assign vic = way_status[result.victim_way];
        assign fl = way_status[flush_way];

        // lowest dirty way of the scanned set
        always_comb begin
                dirty_any = 1'b0;
                dirty_way = 1'b0;
                for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                        if (way_status[w].dirty) begin
                                dirty_any = 1'b1;
                                dirty_way = 1'(w);
                        end
                end
        end

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        state <= IDLE;
                        flush_set <= '0;
                        flush_way <= 1'b0;
                end else begin
                        state <= next_state;
                        flush_set <= next_flush_set;
                        flush_way <= next_flush_way;
                end
        end

        always_comb begin
                next_state = state;
                next_flush_set = flush_set;
                next_flush_way = flush_way;
                dhit = 1'b0;
                touch = 1'b0;
                mem_req = '0;
                way_cmd = '0;
                unique case (state)
                IDLE: begin
                        if (halt) begin
                                next_state = FLUSH_SCAN;
                                next_flush_set = '0;
                        end else if (cpu_req.read || cpu_req.write) begin
                                if (result.hit) begin
                                        dhit = 1'b1;
                                        touch = 1'b1;
                                        if (cpu_req.write) begin
                                                way_cmd[result.hit_way].wen0 =
                                                        ~cpu_req.addr.blk_off;
                                                way_cmd[result.hit_way].wen1 =
                                                        cpu_req.addr.blk_off;
                                                way_cmd[result.hit_way].set_dirty = 1'b1;
                                                way_cmd[result.hit_way].wdata = cpu_req.wdata;
                                        end
                                end else if (result.victim_valid && result.victim_dirty) begin
                                        next_state = WB0;
                                end else begin
                                        next_state = FILL0;
                                end
                        end
                end
                WB0, WB1: begin
                        mem_req.write = 1'b1;
                        mem_req.addr = blk_addr(result.victim_tag, cpu_req.addr.idx,
                                                state == WB1);
                        mem_req.wdata = vic.data[state == WB1];
                        if (!dwait) begin
                                next_state = (state == WB0) ? WB1 : FILL0;
                                if (state == WB1) begin
                                        way_cmd[result.victim_way].clr_dirty = 1'b1;
                                        way_cmd[result.victim_way].clr_valid = 1'b1;
                                end
                        end
                end
                FILL0, FILL1: begin
                        mem_req.read = 1'b1;
                        mem_req.addr = blk_addr(cpu_req.addr.tag, cpu_req.addr.idx,
                                                state == FILL1);
                        if (!dwait) begin
                                way_cmd[result.victim_way].wdata = dload;
                                if (state == FILL0) begin
                                        way_cmd[result.victim_way].wen0 = 1'b1;
                                        next_state = FILL1;
                                end else begin
                                        // block complete so the retry hits in idle
                                        way_cmd[result.victim_way].wen1 = 1'b1;
                                        way_cmd[result.victim_way].tag_load = 1'b1;
                                        way_cmd[result.victim_way].set_valid = 1'b1;
                                        next_state = IDLE;
                                end
                        end
                end
                FLUSH_SCAN: begin
                        if (dirty_any) begin
                                next_flush_way = dirty_way;
                                next_state = FLUSH_WB0;
                        end else if (flush_set == IDX_W'(NUM_SETS - 1)) begin
                                next_state = FLUSH_DONE;
                        end else begin
                                next_flush_set = flush_set + IDX_W'(1);
                        end
                end
                FLUSH_WB0, FLUSH_WB1: begin
                        mem_req.write = 1'b1;
                        mem_req.addr = blk_addr(fl.tag, flush_set, state == FLUSH_WB1);
                        mem_req.wdata = fl.data[state == FLUSH_WB1];
                        if (!dwait) begin
                                next_state = (state == FLUSH_WB0) ? FLUSH_WB1 : FLUSH_SCAN;
                                if (state == FLUSH_WB1) begin
                                        way_cmd[flush_way].clr_dirty = 1'b1;
                                        way_cmd[flush_way].clr_valid = 1'b1;
                                end
                        end
                end
                FLUSH_DONE: begin
                        next_state = FLUSH_DONE;
                end
                default: begin
                        next_state = IDLE;
                end
                endcase
        end

        a_rw_excl: assert property (@(posedge CLK) disable iff (!nRST)
                !(mem_req.read && mem_req.write));

        // back-pressure holds the whole request
        a_hold: assert property (@(posedge CLK) disable iff (!nRST)
                (mem_req.read || mem_req.write) && dwait |=> $stable(mem_req));

endmodule

//--- src/dcache_victim_sel.sv
`timescale 1ns/1ps

module dcache_victim_sel (
        input logic CLK,
        input logic nRST,
        input dcache_bus_pkg::way_status_t [dcache_geom_pkg::NUM_WAYS-1:0] way_status,
        input logic [dcache_geom_pkg::IDX_W-1:0] idx,
        input logic blk_off,
        input logic touch,
        output dcache_bus_pkg::sel_result_t result
);
        import dcache_geom_pkg::*;

        // set bit points at the way not used most recently
        logic [NUM_SETS-1:0] lru;
        logic [NUM_WAYS-1:0] hit_vec;

        always_comb begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                        hit_vec[w] = way_status[w].valid && way_status[w].match;
                end
        end

        always_comb begin
                result = '0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                        if (hit_vec[w]) begin
                                result.hit = 1'b1;
                                result.hit_way = 1'(w);
                        end
                end
                result.hit_word = way_status[result.hit_way].data[blk_off];
                result.victim_way = lru[idx];
                result.victim_valid = way_status[lru[idx]].valid;
                result.victim_dirty = way_status[lru[idx]].dirty;
                result.victim_tag = way_status[lru[idx]].tag;
        end

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        lru <= '0;
                end else if (touch) begin
                        lru[idx] <= ~result.hit_way;
                end
        end

        // a fill never duplicates a resident block
        a_one_hit: assert property (@(posedge CLK) disable iff (!nRST)
                $onehot0(hit_vec));

endmodule

//--- src/dcache_way.sv
`timescale 1ns/1ps

module dcache_way (
        input logic CLK,
        input logic nRST,
        input logic [dcache_geom_pkg::IDX_W-1:0] idx,
        input logic [dcache_geom_pkg::TAG_W-1:0] cmp_tag,
        input dcache_bus_pkg::way_cmd_t cmd,
        output dcache_bus_pkg::way_status_t status
);
        import dcache_geom_pkg::*;

        logic [TAG_W-1:0] tag_mem [NUM_SETS];
        logic [1:0][WORD_W-1:0] data_mem [NUM_SETS];
        logic [NUM_SETS-1:0] valid;
        logic [NUM_SETS-1:0] dirty;

        // frame of the addressed set
        always_comb begin
                status.valid = valid[idx];
                status.dirty = dirty[idx];
                status.tag = tag_mem[idx];
                status.data = data_mem[idx];
                status.match = (tag_mem[idx] == cmp_tag);
        end

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        valid <= '0;
                        dirty <= '0;
                end else begin
                        if (cmd.set_valid) begin
                                valid[idx] <= 1'b1;
                        end else if (cmd.clr_valid) begin
                                valid[idx] <= 1'b0;
                        end
                        if (cmd.set_dirty) begin
                                dirty[idx] <= 1'b1;
                        end else if (cmd.clr_dirty) begin
                                dirty[idx] <= 1'b0;
                        end
                end
        end

        // tag is taken from the lookup address
        always_ff @(posedge CLK) begin
                if (cmd.tag_load) begin
                        tag_mem[idx] <= cmp_tag;
                end
                if (cmd.wen0) begin
                        data_mem[idx][0] <= cmd.wdata;
                end
                if (cmd.wen1) begin
                        data_mem[idx][1] <= cmd.wdata;
                end
        end

        a_valid_cmd: assert property (@(posedge CLK) disable iff (!nRST)
                !(cmd.set_valid && cmd.clr_valid));

endmodule

//--- src/dcache_bus_pkg.sv
package dcache_bus_pkg;

        import dcache_geom_pkg::*;

        // cpu side request, held until dhit
        typedef struct packed {
                logic read;
                logic write;
                dcache_addr_t addr;
                logic [WORD_W-1:0] wdata;
        } dcache_cpu_req_t;

        // memory side request, held until dwait low
        typedef struct packed {
                logic read;
                logic write;
                dcache_addr_t addr;
                logic [WORD_W-1:0] wdata;
        } dcache_mem_req_t;

        // indexed frame of one way
        typedef struct packed {
                logic valid;
                logic dirty;
                logic [TAG_W-1:0] tag;
                logic [1:0][WORD_W-1:0] data;
                logic match;
        } way_status_t;

        typedef struct packed {
                logic wen0;
                logic wen1;
                logic tag_load;
                logic set_valid;
                logic set_dirty;
                logic clr_dirty;
                logic clr_valid;
                logic [WORD_W-1:0] wdata;
        } way_cmd_t;

        typedef enum logic [3:0] {
                IDLE,
                WB0,
                WB1,
                FILL0,
                FILL1,
                FLUSH_SCAN,
                FLUSH_WB0,
                FLUSH_WB1,
                FLUSH_DONE
        } dcache_state_e;

        typedef struct packed {
                logic hit;
                logic hit_way;
                logic [WORD_W-1:0] hit_word;
                logic victim_way;
                logic victim_valid;
                logic victim_dirty;
                logic [TAG_W-1:0] victim_tag;
        } sel_result_t;

endpackage

//--- src/dcache_geom_pkg.sv
package dcache_geom_pkg;

        // word and address width
        localparam int WORD_W = 32;

        localparam int NUM_SETS = 8;
        localparam int IDX_W = 3;
        localparam int TAG_W = 26;

        // one lru bit per set, so two ways only
        localparam int NUM_WAYS = 2;

        // tag 26, index 3, block offset 1, byte offset 2
        typedef struct packed {
                logic [TAG_W-1:0] tag;
                logic [IDX_W-1:0] idx;
                logic blk_off;
                logic [1:0] byte_off;
        } dcache_addr_t;

endpackage
